//--- logic/rename_defines.svh
////////////////////
// sizing for the rename block, 32 arch and 64 phys registers
// the free list depth is phys minus arch, so keep them 2:1 sized
// CKPT_W must cover NUM_CKPT exactly (power of two)
////////////////////
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// register file sizes
`define NUM_ARCH_REGS 32
`define NUM_PHYS_REGS 64

// branch checkpoints open at once
`define NUM_CKPT 4
`define CKPT_W 2

// displaced-tag buffer, one entry per tag in flight
`define AL_DEPTH 32

`endif

//--- logic/rename_pkg.sv
////////////////////
// shared types for the rename block
// tag and index widths follow rename_defines.svh
////////////////////
`include "rename_defines.svh"

package rename_pkg;

    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [`CKPT_W-1:0] ckpt_id_t;

    // one decoded instruction, as strobes from decode
    typedef struct packed {
        logic      valid;
        logic      uses_rs;
        arch_reg_t rs;
        logic      uses_rt;
        arch_reg_t rt;
        logic      uses_rw;
        arch_reg_t rw;
        logic      is_branch;
    } rename_req_t;

    // registered rename result, one cycle after the request
    typedef struct packed {
        logic      valid;
        phys_tag_t rs_tag;
        phys_tag_t rt_tag;
        phys_tag_t rw_tag;
        phys_tag_t old_tag;
        logic      rs_ready;
        logic      rt_ready;
        ckpt_id_t  ckpt_id;
    } rename_rsp_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } wb_t;

    // always about the oldest open branch
    typedef struct packed {
        logic valid;
        logic mispredict;
    } resolve_t;

    typedef enum logic {
        st_run,
        st_recover
    } ctrl_state_e;

endpackage

//--- logic/free_list.sv
////////////////////
// circular buffer of free tags, reset holds 32..63 in order
// pointers carry a wrap bit so full and empty differ
// alloc while empty is not checked here, stall covers it
////////////////////
`timescale 1ns/100ps
`include "rename_defines.svh"

module free_list (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  logic                 push,
    input  rename_pkg::phys_tag_t push_tag,
    input  logic                 ckpt_save,
    input  rename_pkg::ckpt_id_t save_id,
    input  logic                 ckpt_restore,
    input  rename_pkg::ckpt_id_t restore_id,
    output rename_pkg::phys_tag_t new_tag,
    output logic                 fl_empty
);

    localparam int DEPTH = `NUM_PHYS_REGS - `NUM_ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH) + 1;

    rename_pkg::phys_tag_t mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] count;
    logic [PTR_W-1:0] head_next;
    logic [PTR_W-1:0] tail_next;
    // head as seen after this cycle's alloc, one per checkpoint
    logic [PTR_W-1:0] saved_head [`NUM_CKPT];

    // wrap bit makes the difference an exact occupancy
    assign count    = tail - head;
    assign fl_empty = (count == '0);
    assign new_tag  = mem[head[PTR_W-2:0]];

    assign head_next = head + PTR_W'(alloc);
    assign tail_next = tail + PTR_W'(push);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= PTR_W'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= rename_pkg::phys_tag_t'(`NUM_ARCH_REGS + i);
            end
        end else begin
            if (push) begin
                mem[tail[PTR_W-2:0]] <= push_tag;
            end
            tail <= tail_next;
            // restore rewinds head, count follows from the live tail
            if (ckpt_restore) begin
                head <= saved_head[restore_id];
            end else begin
                head <= head_next;
            end
        end
    end

    // snapshot includes the branch's own allocation
    always_ff @(posedge clk) begin
        if (ckpt_save) begin
            saved_head[save_id] <= head_next;
        end
    end

endmodule

//--- logic/active_list.sv
////////////////////
// displaced tags in program order, oldest popped on commit
// depth matches the free list, so it cannot overflow
////////////////////
`timescale 1ns/100ps
`include "rename_defines.svh"

module active_list (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  rename_pkg::phys_tag_t old_tag,
    input  logic                 commit,
    input  logic                 ckpt_save,
    input  rename_pkg::ckpt_id_t save_id,
    input  logic                 ckpt_restore,
    input  rename_pkg::ckpt_id_t restore_id,
    output logic                 pop_valid,
    output rename_pkg::phys_tag_t pop_tag
);

    localparam int PTR_W = $clog2(`AL_DEPTH) + 1;

    rename_pkg::phys_tag_t mem [`AL_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] tail_next;
    logic             empty;
    logic [PTR_W-1:0] saved_tail [`NUM_CKPT];

    assign empty     = (head == tail);
    assign tail_next = tail + PTR_W'(alloc);

    // pop goes straight to the free list push
    assign pop_valid = commit && !empty;
    assign pop_tag   = mem[head[PTR_W-2:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (pop_valid) begin
                head <= head + 1'b1;
            end
            // truncate younger entries back to the branch
            if (ckpt_restore) begin
                tail <= saved_tail[restore_id];
            end else begin
                tail <= tail_next;
            end
        end
    end

    // payload storage, no reset needed
    always_ff @(posedge clk) begin
        if (alloc) begin
            mem[tail[PTR_W-2:0]] <= old_tag;
        end
    end

    // tail after the branch's own entry
    always_ff @(posedge clk) begin
        if (ckpt_save) begin
            saved_tail[save_id] <= tail_next;
        end
    end

endmodule

//--- logic/map_table.sv
////////////////////
// arch to phys map, identity after reset
// sources read the map before this cycle's write
////////////////////
`timescale 1ns/100ps
`include "rename_defines.svh"

module map_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rename_pkg::rename_req_t dec,
    input  logic                    alloc,
    input  rename_pkg::phys_tag_t   new_tag,
    input  logic                    ckpt_save,
    input  rename_pkg::ckpt_id_t    save_id,
    input  logic                    ckpt_restore,
    input  rename_pkg::ckpt_id_t    restore_id,
    output rename_pkg::phys_tag_t   rs_tag,
    output rename_pkg::phys_tag_t   rt_tag,
    output rename_pkg::phys_tag_t   old_tag
);

    rename_pkg::phys_tag_t map_q [`NUM_ARCH_REGS];
    rename_pkg::phys_tag_t map_upd [`NUM_ARCH_REGS];
    rename_pkg::phys_tag_t snap [`NUM_CKPT][`NUM_ARCH_REGS];

    // lookups from the current map
    assign rs_tag  = map_q[dec.rs];
    assign rt_tag  = map_q[dec.rt];
    assign old_tag = map_q[dec.rw];

    // map with this cycle's destination applied
    always_comb begin
        map_upd = map_q;
        if (alloc) begin
            map_upd[dec.rw] = new_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else if (ckpt_restore) begin
            // whole snapshot back in one cycle
            map_q <= snap[restore_id];
        end else begin
            map_q <= map_upd;
        end
    end

    // branch snapshot sees its own rw update
    always_ff @(posedge clk) begin
        if (ckpt_save) begin
            snap[save_id] <= map_upd;
        end
    end

endmodule

//--- logic/busy_table.sv
////////////////////
// pending-writeback bit per phys tag
// ready flags use the table before this cycle's writeback
////////////////////
`timescale 1ns/100ps
`include "rename_defines.svh"

module busy_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc,
    input  rename_pkg::phys_tag_t new_tag,
    input  rename_pkg::wb_t       wb,
    input  rename_pkg::phys_tag_t rs_tag,
    input  rename_pkg::phys_tag_t rt_tag,
    input  logic                  ckpt_save,
    input  rename_pkg::ckpt_id_t  save_id,
    input  logic                  ckpt_restore,
    input  rename_pkg::ckpt_id_t  restore_id,
    output logic                  rs_ready,
    output logic                  rt_ready
);

    logic [`NUM_PHYS_REGS-1:0] busy_q;
    logic [`NUM_PHYS_REGS-1:0] busy_next;
    logic [`NUM_CKPT-1:0][`NUM_PHYS_REGS-1:0] snap;

    assign rs_ready = !busy_q[rs_tag];
    assign rt_ready = !busy_q[rt_tag];

    // clear on writeback, set on allocation
    always_comb begin
        busy_next = busy_q;
        if (wb.valid) begin
            busy_next[wb.tag] = 1'b0;
        end
        if (alloc) begin
            busy_next[new_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (ckpt_restore) begin
            // AND keeps writebacks done after the checkpoint
            busy_q <= snap[restore_id] & busy_next;
        end else begin
            busy_q <= busy_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ckpt_save) begin
            snap[save_id] <= busy_next;
        end
    end

endmodule

//--- logic/rename_ctrl.sv
////////////////////
// checkpoint stack and stall for the rename block
// resolve must name the oldest open branch
// one recover cycle follows every mispredict
////////////////////
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rename_pkg::rename_req_t dec,
    input  rename_pkg::resolve_t    resolve,
    input  logic                    fl_empty,
    output logic                    alloc,
    output logic                    ckpt_save,
    output rename_pkg::ckpt_id_t    save_id,
    output logic                    ckpt_restore,
    output rename_pkg::ckpt_id_t    restore_id,
    output logic                    rsp_valid,
    output logic                    stall
);

    localparam logic [`CKPT_W:0] CKPT_FULL = `NUM_CKPT;

    rename_pkg::ctrl_state_e state;
    // wr_idx is the next free slot, rd_idx the oldest open branch
    rename_pkg::ckpt_id_t    wr_idx;
    rename_pkg::ckpt_id_t    rd_idx;
    logic [`CKPT_W:0]        open_cnt;
    logic                    accept;
    logic                    mispredict;
    logic                    resolve_ok;

    // resolve with nothing open is dropped
    assign mispredict = resolve.valid && resolve.mispredict && (open_cnt != '0);
    assign resolve_ok = resolve.valid && !resolve.mispredict && (open_cnt != '0);

    assign stall = (state == rename_pkg::st_recover)
                 || fl_empty
                 || (open_cnt == CKPT_FULL);

    // a request next to a mispredict is wrong-path, drop it
    assign accept = dec.valid && !stall && !mispredict;

    assign rsp_valid    = accept;
    assign alloc        = accept && dec.uses_rw;
    assign ckpt_save    = accept && dec.is_branch;
    assign save_id      = wr_idx;
    assign ckpt_restore = mispredict;
    assign restore_id   = rd_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rename_pkg::st_run;
            wr_idx   <= '0;
            rd_idx   <= '0;
            open_cnt <= '0;
        end else begin
            case (state)
                rename_pkg::st_run: begin
                    if (mispredict) begin
                        state <= rename_pkg::st_recover;
                    end
                end
                rename_pkg::st_recover: begin
                    state <= rename_pkg::st_run;
                end
                default: begin
                    state <= rename_pkg::st_run;
                end
            endcase

            if (mispredict) begin
                // oldest branch and all younger ones are gone
                wr_idx   <= rd_idx;
                open_cnt <= '0;
            end else begin
                if (ckpt_save) begin
                    wr_idx <= wr_idx + 1'b1;
                end
                if (resolve_ok) begin
                    rd_idx <= rd_idx + 1'b1;
                end
                // save and pop together leave the count alone
                case ({ckpt_save, resolve_ok})
                    2'b10: open_cnt <= open_cnt + 1'b1;
                    2'b01: open_cnt <= open_cnt - 1'b1;
                    default: open_cnt <= open_cnt;
                endcase
            end
        end
    end

endmodule

//--- logic/register_rename.sv
////////////////////
// rename top, one-cycle latency from dec to rsp
// rw_tag and old_tag are only meaningful when rw is used
////////////////////
`timescale 1ns/100ps

module register_rename (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rename_pkg::rename_req_t dec,
    input  rename_pkg::wb_t         wb,
    input  logic                    commit,
    input  rename_pkg::resolve_t    resolve,
    output rename_pkg::rename_rsp_t rsp,
    output logic                    stall
);

    logic                  alloc;
    logic                  ckpt_save;
    logic                  ckpt_restore;
    logic                  rsp_valid;
    logic                  fl_empty;
    logic                  pop_valid;
    logic                  rs_ready;
    logic                  rt_ready;
    rename_pkg::ckpt_id_t  save_id;
    rename_pkg::ckpt_id_t  restore_id;
    rename_pkg::phys_tag_t new_tag;
    rename_pkg::phys_tag_t pop_tag;
    rename_pkg::phys_tag_t rs_tag;
    rename_pkg::phys_tag_t rt_tag;
    rename_pkg::phys_tag_t old_tag;

    rename_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .resolve      (resolve),
        .fl_empty     (fl_empty),
        .alloc        (alloc),
        .ckpt_save    (ckpt_save),
        .save_id      (save_id),
        .ckpt_restore (ckpt_restore),
        .restore_id   (restore_id),
        .rsp_valid    (rsp_valid),
        .stall        (stall)
    );

    // committed displaced tags feed the free list tail
    free_list u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .push         (pop_valid),
        .push_tag     (pop_tag),
        .ckpt_save    (ckpt_save),
        .save_id      (save_id),
        .ckpt_restore (ckpt_restore),
        .restore_id   (restore_id),
        .new_tag      (new_tag),
        .fl_empty     (fl_empty)
    );

    active_list u_active_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .old_tag      (old_tag),
        .commit       (commit),
        .ckpt_save    (ckpt_save),
        .save_id      (save_id),
        .ckpt_restore (ckpt_restore),
        .restore_id   (restore_id),
        .pop_valid    (pop_valid),
        .pop_tag      (pop_tag)
    );

    map_table u_map_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .alloc        (alloc),
        .new_tag      (new_tag),
        .ckpt_save    (ckpt_save),
        .save_id      (save_id),
        .ckpt_restore (ckpt_restore),
        .restore_id   (restore_id),
        .rs_tag       (rs_tag),
        .rt_tag       (rt_tag),
        .old_tag      (old_tag)
    );

    busy_table u_busy_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .new_tag      (new_tag),
        .wb           (wb),
        .rs_tag       (rs_tag),
        .rt_tag       (rt_tag),
        .ckpt_save    (ckpt_save),
        .save_id      (save_id),
        .ckpt_restore (ckpt_restore),
        .restore_id   (restore_id),
        .rs_ready     (rs_ready),
        .rt_ready     (rt_ready)
    );

    // output register, same edge as all rename state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.valid    <= rsp_valid;
            rsp.rs_tag   <= rs_tag;
            rsp.rt_tag   <= rt_tag;
            rsp.rw_tag   <= new_tag;
            rsp.old_tag  <= old_tag;
            rsp.rs_ready <= rs_ready;
            rsp.rt_ready <= rt_ready;
            // checkpoint the instruction falls under, its own for a branch
            rsp.ckpt_id  <= save_id;
        end
    end

endmodule

//--- tests/rename_props.sv
////////////////////
// port-level properties, bound into register_rename
// checks are off while rst_n is low
////////////////////
`timescale 1ns/100ps

module rename_props (
    input logic                    clk,
    input logic                    rst_n,
    input rename_pkg::rename_req_t dec,
    input logic                    commit,
    input rename_pkg::rename_rsp_t rsp,
    input logic                    stall
);

    // set once any rename has come out
    logic seen_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_valid <= 1'b0;
        end else if (rsp.valid) begin
            seen_valid <= 1'b1;
        end
    end

    // no stall right out of reset
    a_no_stall_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall)
        else $error("stall high in the first cycle after reset");

    // a commit needs something renamed first
    a_commit_after_rename: assert property (@(posedge clk) disable iff (!rst_n)
        commit |-> (seen_valid || rsp.valid))
        else $error("commit arrived before any rename response");

    // a stalled request never produces a response
    a_stall_blocks_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && dec.valid) |=> !rsp.valid)
        else $error("rsp.valid followed a request made under stall");

endmodule

bind register_rename rename_props i_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .dec    (dec),
    .commit (commit),
    .rsp    (rsp),
    .stall  (stall)
);

//--- tests/rename_tb.sv
////////////////////
// table-driven testbench with a reference model of the rename state
// one operation per row with the expected stall as a column
// rename rows under stall are still driven and must be dropped
// rsp is compared at the falling edge after each row
////////////////////
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_tb;

    localparam logic [2:0] OP_REN = 3'd0;
    localparam logic [2:0] OP_WB  = 3'd1;
    localparam logic [2:0] OP_COM = 3'd2;
    localparam logic [2:0] OP_OK  = 3'd3;
    localparam logic [2:0] OP_MIS = 3'd4;

    // one table row holds operation, test group, expected stall and operands
    typedef struct packed {
        logic [2:0] op;
        logic [2:0] grp;
        logic       st;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rw;
        logic       w;
        logic       br;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    rename_pkg::rename_req_t dec;
    rename_pkg::wb_t         wb;
    logic                    commit;
    rename_pkg::resolve_t    resolve;
    rename_pkg::rename_rsp_t rsp;
    logic                    stall;

    row_t tbl [$];
    int   n_errors = 0;
    int   n_checks = 0;
    int   cycles = 0;
    int   max_cycles = 0;

    // reference model state
    int                      m_map [`NUM_ARCH_REGS];
    int                      m_free [$];
    int                      m_al [$];
    int                      m_hist [$];
    bit [`NUM_PHYS_REGS-1:0] m_busy;
    int                      c_map [`NUM_CKPT][`NUM_ARCH_REGS];
    bit [`NUM_PHYS_REGS-1:0] c_busy [`NUM_CKPT];
    int                      c_since [`NUM_CKPT];
    int                      wr_ptr;
    int                      rd_ptr;
    int                      open_n;

    // prediction for the row just applied
    int exp_valid;
    int exp_w;
    int exp_rs;
    int exp_rt;
    int exp_rs_rdy;
    int exp_rt_rdy;
    int exp_rw;
    int exp_old;
    int exp_ck;
    int chk_idx;
    int chk_grp;

    always #5 clk = ~clk;

    // run limit from table length, reset and a margin
    always @(posedge clk) begin
        cycles++;
        if (max_cycles > 0 && cycles > max_cycles) begin
            $display("timeout: run went past %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    register_rename i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .wb      (wb),
        .commit  (commit),
        .resolve (resolve),
        .rsp     (rsp),
        .stall   (stall)
    );

    function automatic string test_name(input int grp);
        case (grp)
            0: return "reset_map";
            1: return "dep_ready";
            2: return "free_wrap";
            3: return "mispredict";
            default: return "resolve";
        endcase
    endfunction

    task automatic add_ren(input int grp, input bit st, input int rs, input int rt,
                           input int rw, input bit w, input bit br);
        tbl.push_back('{OP_REN, 3'(grp), st, 5'(rs), 5'(rt), 5'(rw), w, br});
    endtask

    task automatic add_op(input int grp, input bit st, input logic [2:0] op, input int rw);
        tbl.push_back('{op, 3'(grp), st, 5'd0, 5'd0, 5'(rw), 1'b0, 1'b0});
    endtask

    task automatic build_table();
        // identity sources and tags from 32 upward
        add_ren(0, 0, 1, 2, 3, 1, 0);
        add_ren(0, 0, 4, 5, 6, 1, 0);
        // fresh tags are busy until written back
        add_ren(1, 0, 3, 6, 7, 1, 0);
        add_op(1, 0, OP_WB, 3);
        // reads and writes r3 and sees the old tag
        add_ren(1, 0, 3, 3, 3, 1, 0);
        add_op(1, 0, OP_WB, 6);
        add_op(1, 0, OP_WB, 7);
        add_op(1, 0, OP_WB, 3);
        // drain the rest of the free list
        for (int i = 0; i < 28; i++) begin
            add_ren(2, 0, i % 8, (i + 3) % 8, 8 + i % 20, 1, 0);
        end
        add_ren(2, 1, 1, 2, 12, 1, 0);
        add_op(2, 1, OP_COM, 0);
        add_op(2, 0, OP_COM, 0);
        add_op(2, 0, OP_COM, 0);
        // committed tags come back in commit order
        add_ren(2, 0, 1, 2, 12, 1, 0);
        add_ren(2, 0, 1, 2, 13, 1, 0);
        add_ren(2, 0, 1, 2, 14, 1, 0);
        add_op(2, 1, OP_COM, 0);
        for (int i = 0; i < 11; i++) begin
            add_op(2, 0, OP_COM, 0);
        end
        // r11 renamed before the branch and written back after it
        add_ren(3, 0, 0, 0, 11, 1, 0);
        add_ren(3, 0, 1, 2, 0, 0, 1);
        add_ren(3, 0, 0, 0, 1, 1, 0);
        add_op(3, 0, OP_WB, 11);
        add_ren(3, 0, 1, 1, 2, 1, 0);
        add_op(3, 0, OP_MIS, 0);
        add_ren(3, 1, 1, 11, 5, 1, 0);
        add_ren(3, 0, 1, 11, 5, 1, 0);
        add_ren(3, 0, 2, 5, 0, 0, 0);
        // correct resolve keeps the younger mapping
        add_ren(4, 0, 0, 0, 0, 0, 1);
        add_ren(4, 0, 0, 0, 9, 1, 0);
        add_op(4, 0, OP_OK, 0);
        add_ren(4, 0, 9, 5, 0, 0, 0);
        for (int i = 0; i < 4; i++) begin
            add_ren(4, 0, 0, 0, 0, 0, 1);
        end
        // four open branches hold stall until one resolves
        add_ren(4, 1, 9, 9, 20, 1, 0);
        add_op(4, 1, OP_WB, 9);
        add_op(4, 1, OP_OK, 0);
        add_ren(4, 0, 9, 0, 20, 1, 0);
        add_ren(4, 0, 0, 0, 0, 0, 1);
        add_op(4, 1, OP_MIS, 0);
        add_ren(4, 1, 20, 9, 21, 1, 0);
        add_ren(4, 0, 20, 9, 21, 1, 0);
    endtask

    task automatic model_reset();
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            m_map[i] = i;
        end
        for (int t = `NUM_ARCH_REGS; t < `NUM_PHYS_REGS; t++) begin
            m_free.push_back(t);
        end
        m_busy = '0;
        wr_ptr = 0;
        rd_ptr = 0;
        open_n = 0;
        exp_valid = 0;
    endtask

    task automatic model_rename(input row_t r);
        exp_valid  = 1;
        exp_w      = r.w;
        exp_rs     = m_map[r.rs];
        exp_rt     = m_map[r.rt];
        exp_rs_rdy = !m_busy[exp_rs];
        exp_rt_rdy = !m_busy[exp_rt];
        exp_ck     = wr_ptr;
        if (r.w) begin
            exp_rw  = m_free.pop_front();
            exp_old = m_map[r.rw];
            m_al.push_back(exp_old);
            m_map[r.rw] = exp_rw;
            m_busy[exp_rw] = 1'b1;
            m_hist.push_back(exp_rw);
            // every open checkpoint must hand this tag back on a mispredict
            for (int k = 0; k < open_n; k++) begin
                c_since[(rd_ptr + k) % `NUM_CKPT]++;
            end
        end
        // snapshot taken after the branch's own update
        if (r.br) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                c_map[wr_ptr][i] = m_map[i];
            end
            c_busy[wr_ptr]  = m_busy;
            c_since[wr_ptr] = 0;
            wr_ptr = (wr_ptr + 1) % `NUM_CKPT;
            open_n++;
        end
    endtask

    task automatic model_mispredict();
        int tag;
        // younger tags go back to the free head in allocation order
        for (int i = 0; i < c_since[rd_ptr]; i++) begin
            tag = m_hist.pop_back();
            m_free.push_front(tag);
            void'(m_al.pop_back());
        end
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            m_map[i] = c_map[rd_ptr][i];
        end
        m_busy = m_busy & c_busy[rd_ptr];
        wr_ptr = rd_ptr;
        open_n = 0;
    endtask

    // drive one row on the falling edge and advance the model
    task automatic apply_row(input row_t r);
        int tag;
        dec       = '0;
        wb        = '0;
        commit    = 1'b0;
        resolve   = '0;
        exp_valid = 0;
        case (r.op)
            OP_REN: begin
                dec.valid     = 1'b1;
                dec.uses_rs   = 1'b1;
                dec.rs        = r.rs;
                dec.uses_rt   = 1'b1;
                dec.rt        = r.rt;
                dec.uses_rw   = r.w;
                dec.rw        = r.rw;
                dec.is_branch = r.br;
                // a request under stall leaves the rename state alone
                if (!r.st) begin
                    model_rename(r);
                end
            end
            OP_WB: begin
                wb.valid = 1'b1;
                wb.tag   = rename_pkg::phys_tag_t'(m_map[r.rw]);
                m_busy[m_map[r.rw]] = 1'b0;
            end
            OP_COM: begin
                commit = 1'b1;
                tag = m_al.pop_front();
                m_free.push_back(tag);
            end
            OP_OK: begin
                resolve.valid = 1'b1;
                rd_ptr = (rd_ptr + 1) % `NUM_CKPT;
                open_n--;
            end
            default: begin
                resolve.valid      = 1'b1;
                resolve.mispredict = 1'b1;
                model_mispredict();
            end
        endcase
    endtask

    task automatic check_val(input int grp, input int idx, input string field,
                             input int exp, input int act);
        n_checks++;
        assert (exp == act) else begin
            n_errors++;
            $display("FAILED %s row %0d %s: expected %0d actual %0d",
                     test_name(grp), idx, field, exp, act);
        end
    endtask

    task automatic check_rsp();
        check_val(chk_grp, chk_idx, "rsp.valid", exp_valid, rsp.valid);
        if (exp_valid != 0 && rsp.valid) begin
            check_val(chk_grp, chk_idx, "rs_tag", exp_rs, rsp.rs_tag);
            check_val(chk_grp, chk_idx, "rt_tag", exp_rt, rsp.rt_tag);
            check_val(chk_grp, chk_idx, "rs_ready", exp_rs_rdy, rsp.rs_ready);
            check_val(chk_grp, chk_idx, "rt_ready", exp_rt_rdy, rsp.rt_ready);
            check_val(chk_grp, chk_idx, "ckpt_id", exp_ck, rsp.ckpt_id);
            if (exp_w != 0) begin
                check_val(chk_grp, chk_idx, "rw_tag", exp_rw, rsp.rw_tag);
                check_val(chk_grp, chk_idx, "old_tag", exp_old, rsp.old_tag);
            end
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        dec     = '0;
        wb      = '0;
        commit  = 1'b0;
        resolve = '0;
        chk_idx = 0;
        chk_grp = 0;
        build_table();
        max_cycles = tbl.size() + 10 + 16;
        model_reset();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            @(negedge clk);
            check_rsp();
            check_val(tbl[i].grp, i, "stall", tbl[i].st, stall);
            apply_row(tbl[i]);
            chk_idx = i;
            chk_grp = tbl[i].grp;
        end
        // last row's response
        @(negedge clk);
        check_rsp();
        dec     = '0;
        wb      = '0;
        commit  = 1'b0;
        resolve = '0;
        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/rename_pkg.sv
logic/free_list.sv
logic/active_list.sv
logic/map_table.sv
logic/busy_table.sv
logic/rename_ctrl.sv
logic/register_rename.sv
tests/rename_props.sv
tests/rename_tb.sv

//--- Bender.yml
package:
  name: register_rename

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rename_pkg.sv
      - logic/free_list.sv
      - logic/active_list.sv
      - logic/map_table.sv
      - logic/busy_table.sv
      - logic/rename_ctrl.sv
      - logic/register_rename.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/rename_props.sv
      - tests/rename_tb.sv
